// File: hdl/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////
    // widths and constants
    ////////////////////////////////////////

    // one instruction address, byte granular
    typedef logic [31:0] fetch_addr_t;

    // csr select
    typedef logic [1:0] csr_addr_t;

    // btb tag, pc bits 31..7
    typedef logic [24:0] btb_tag_t;

    // reset vector
    localparam fetch_addr_t RESET_PC = 32'h0000_0100;

    // two 4-byte instructions per fetch group
    localparam fetch_addr_t FETCH_STRIDE = 32'd8;

    // direct-mapped btb, indexed by pc[6:3]
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W = 4;

    // csr map
    localparam csr_addr_t CSR_EENTRY = 2'd0;
    localparam csr_addr_t CSR_ERA = 2'd1;
    // bit 0 is the interrupt enable
    localparam csr_addr_t CSR_CTRL = 2'd2;

    ////////////////////////////////////////
    // bundles
    ////////////////////////////////////////

    // csr write port, 35 bits
    typedef struct packed {
        logic        en;
        csr_addr_t   addr;
        fetch_addr_t data;
    } csr_wr_t;

    // branch resolution from the back end, 66 bits
    typedef struct packed {
        logic        valid;
        logic        taken;
        fetch_addr_t pc;
        fetch_addr_t target;
    } bp_update_t;

    // btb lookup result, 33 bits
    typedef struct packed {
        logic        hit;
        fetch_addr_t target;
    } bp_pred_t;

    // fetch packet to decode, 36 bits
    typedef struct packed {
        logic        valid;
        fetch_addr_t pc;
        logic        pred_taken;
        logic        excp_int;
        logic        excp_adef;
    } fetch_pkt_t;

endpackage

// File: hdl/fetch_csr.sv
module fetch_csr (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::csr_wr_t     csr_wr_i,
    input  fetch_pkg::csr_addr_t   csr_raddr_i,
    input  logic                   exc_flush_i,
    input  fetch_pkg::fetch_addr_t flush_pc_i,
    output fetch_pkg::fetch_addr_t csr_rdata_o,
    output fetch_pkg::fetch_addr_t eentry_o,
    output logic                   irq_en_o
);

    fetch_pkg::fetch_addr_t eentry_q;
    fetch_pkg::fetch_addr_t era_q;
    logic                   irq_en_q;

    ////////////////////////////////////////
    // register file
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            eentry_q <= '0;
            era_q    <= '0;
            irq_en_q <= 1'b0;
        end else begin
            if (csr_wr_i.en && csr_wr_i.addr == fetch_pkg::CSR_EENTRY) begin
                eentry_q <= csr_wr_i.data;
            end
            if (csr_wr_i.en && csr_wr_i.addr == fetch_pkg::CSR_CTRL) begin
                irq_en_q <= csr_wr_i.data[0];
            end
            // flush capture beats a software write to era
            if (exc_flush_i) begin
                era_q <= flush_pc_i;
            end else if (csr_wr_i.en && csr_wr_i.addr == fetch_pkg::CSR_ERA) begin
                era_q <= csr_wr_i.data;
            end
        end
    end

    ////////////////////////////////////////
    // read mux
    ////////////////////////////////////////

    always_comb begin
        case (csr_raddr_i)
            fetch_pkg::CSR_EENTRY: csr_rdata_o = eentry_q;
            fetch_pkg::CSR_ERA:    csr_rdata_o = era_q;
            fetch_pkg::CSR_CTRL:   csr_rdata_o = fetch_pkg::fetch_addr_t'(irq_en_q);
            // unmapped reads zero
            default:               csr_rdata_o = '0;
        endcase
    end

    // straight to the pc generator
    assign eentry_o = eentry_q;
    assign irq_en_o = irq_en_q;

endmodule

// File: hdl/branch_target_buffer.sv
module branch_target_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::fetch_addr_t lookup_pc_i,
    output fetch_pkg::bp_pred_t    pred_o,
    input  fetch_pkg::bp_update_t  bp_upd_i
);

    // index sits right above the 8-byte group offset
    localparam int IDX_LSB = 3;
    localparam int IDX_MSB = IDX_LSB + fetch_pkg::BTB_IDX_W - 1;
    localparam int TAG_LSB = IDX_MSB + 1;

    // entry storage
    logic                   valid_q  [0:fetch_pkg::BTB_ENTRIES-1];
    fetch_pkg::btb_tag_t    tag_q    [0:fetch_pkg::BTB_ENTRIES-1];
    fetch_pkg::fetch_addr_t target_q [0:fetch_pkg::BTB_ENTRIES-1];

    logic [fetch_pkg::BTB_IDX_W-1:0] lookup_idx;
    fetch_pkg::btb_tag_t             lookup_tag;
    logic [fetch_pkg::BTB_IDX_W-1:0] upd_idx;
    fetch_pkg::btb_tag_t             upd_tag;
    logic                            upd_tag_match;

    ////////////////////////////////////////
    // lookup, combinational
    ////////////////////////////////////////

    assign lookup_idx = lookup_pc_i[IDX_MSB:IDX_LSB];
    assign lookup_tag = lookup_pc_i[31:TAG_LSB];

    // hit needs a live entry and a full tag compare
    assign pred_o.hit    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign pred_o.target = target_q[lookup_idx];

    ////////////////////////////////////////
    // update from the back end
    ////////////////////////////////////////

    assign upd_idx = bp_upd_i.pc[IDX_MSB:IDX_LSB];
    assign upd_tag = bp_upd_i.pc[31:TAG_LSB];

    // not-taken only evicts its own branch, not an alias
    assign upd_tag_match = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

    // valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fetch_pkg::BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (bp_upd_i.valid) begin
            if (bp_upd_i.taken) begin
                valid_q[upd_idx] <= 1'b1;
            end else if (upd_tag_match) begin
                valid_q[upd_idx] <= 1'b0;
            end
        end
    end

    // tag and target payload
    // only a taken update allocates, overwriting whatever was there
    always_ff @(posedge clk) begin
        if (bp_upd_i.valid && bp_upd_i.taken) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= bp_upd_i.target;
        end
    end

endmodule

// File: hdl/pc_gen.sv
module pc_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall_i,
    input  logic                   redirect_i,
    input  fetch_pkg::fetch_addr_t redirect_pc_i,
    input  logic                   exc_flush_i,
    input  fetch_pkg::fetch_addr_t eentry_i,
    input  logic                   irq_i,
    input  logic                   irq_en_i,
    input  fetch_pkg::bp_pred_t    pred_i,
    output fetch_pkg::fetch_addr_t cur_pc_o,
    output fetch_pkg::fetch_pkt_t  fetch_pkt_o
);

    fetch_pkg::fetch_pkt_t pkt_q;
    fetch_pkg::fetch_pkt_t pkt_d;
    logic                  load;

    ////////////////////////////////////////
    // next pc select
    ////////////////////////////////////////

    // flush > redirect > stall > predicted > sequential
    // reset is handled in the register itself
    always_comb begin
        pkt_d            = pkt_q;
        pkt_d.valid      = 1'b1;
        pkt_d.pred_taken = 1'b0;
        load             = 1'b1;
        if (exc_flush_i) begin
            pkt_d.pc = eentry_i;
        end else if (redirect_i) begin
            pkt_d.pc = redirect_pc_i;
        end else if (stall_i) begin
            // whole packet frozen, marks included
            load = 1'b0;
        end else if (!pkt_q.valid) begin
            // first group out of reset fetches the reset vector itself
            pkt_d.pc = pkt_q.pc;
        end else if (pred_i.hit) begin
            pkt_d.pc         = pred_i.target;
            pkt_d.pred_taken = 1'b1;
        end else begin
            pkt_d.pc = pkt_q.pc + fetch_pkg::FETCH_STRIDE;
        end
        // marks follow the pc they are stored with
        pkt_d.excp_int  = irq_i && irq_en_i;
        pkt_d.excp_adef = (pkt_d.pc[1:0] != 2'b00);
    end

    ////////////////////////////////////////
    // packet register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_q.valid      <= 1'b0;
            pkt_q.pc         <= fetch_pkg::RESET_PC;
            pkt_q.pred_taken <= 1'b0;
            pkt_q.excp_int   <= 1'b0;
            pkt_q.excp_adef  <= 1'b0;
        end else if (load) begin
            pkt_q <= pkt_d;
        end
    end

    // btb lookup and era capture both see the registered pc
    assign cur_pc_o    = pkt_q.pc;
    assign fetch_pkt_o = pkt_q;

endmodule

// File: hdl/fetch_frontend.sv
module fetch_frontend (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall_i,
    input  logic                   redirect_i,
    input  fetch_pkg::fetch_addr_t redirect_pc_i,
    input  logic                   exc_flush_i,
    input  logic                   irq_i,
    input  fetch_pkg::bp_update_t  bp_upd_i,
    input  fetch_pkg::csr_wr_t     csr_wr_i,
    input  fetch_pkg::csr_addr_t   csr_raddr_i,
    output fetch_pkg::fetch_pkt_t  fetch_pkt_o,
    output fetch_pkg::fetch_addr_t csr_rdata_o
);

    // internal nets
    fetch_pkg::fetch_addr_t cur_pc;
    fetch_pkg::bp_pred_t    bp_pred;
    fetch_pkg::fetch_addr_t eentry;
    logic                   irq_en;

    ////////////////////////////////////////
    // csr, steers the pc generator
    ////////////////////////////////////////

    fetch_csr u_fetch_csr (
        .clk         (clk),
        .rst         (rst),
        .csr_wr_i    (csr_wr_i),
        .csr_raddr_i (csr_raddr_i),
        .exc_flush_i (exc_flush_i),
        .flush_pc_i  (cur_pc),
        .csr_rdata_o (csr_rdata_o),
        .eentry_o    (eentry),
        .irq_en_o    (irq_en)
    );

    // btb looks up the current pc
    branch_target_buffer u_branch_target_buffer (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (cur_pc),
        .pred_o      (bp_pred),
        .bp_upd_i    (bp_upd_i)
    );

    ////////////////////////////////////////
    // pc and packet
    ////////////////////////////////////////

    pc_gen u_pc_gen (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .exc_flush_i   (exc_flush_i),
        .eentry_i      (eentry),
        .irq_i         (irq_i),
        .irq_en_i      (irq_en),
        .pred_i        (bp_pred),
        .cur_pc_o      (cur_pc),
        .fetch_pkt_o   (fetch_pkt_o)
    );

endmodule

// File: verif/fetch_checker.sv
module fetch_checker (
    input  logic                   clk,
    input  logic                   check_en_i,
    input  logic [159:0]           test_name_i,
    input  fetch_pkg::fetch_pkt_t  exp_pkt_i,
    input  fetch_pkg::fetch_addr_t exp_rdata_i,
    input  fetch_pkg::fetch_pkt_t  fetch_pkt_i,
    input  fetch_pkg::fetch_addr_t csr_rdata_i,
    output int                     error_count_o,
    output int                     check_count_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int errors = 0;
    int checks = 0;

    // packet fields spelled out for the error line
    function automatic string pkt_text(input fetch_pkg::fetch_pkt_t pkt);
        return $sformatf("valid=%0b pc=%h pred=%0b int=%0b adef=%0b",
                         pkt.valid, pkt.pc, pkt.pred_taken, pkt.excp_int, pkt.excp_adef);
    endfunction

    ////////////////////////////////////////
    // compare on every rising edge
    ////////////////////////////////////////

    // outputs still hold the previous cycle here, inputs moved 2 ns after the edge
    always @(posedge clk) begin
        if (check_en_i) begin
            checks++;
            if (fetch_pkt_i !== exp_pkt_i) begin
                errors++;
                $display("[ERROR] %0s: fetch_pkt expected %s actual %s", test_name_i,
                         pkt_text(exp_pkt_i), pkt_text(fetch_pkt_i));
            end
            // read port, combinational from the csr registers
            if (csr_rdata_i !== exp_rdata_i) begin
                errors++;
                $display("[ERROR] %0s: csr_rdata expected %h actual %h", test_name_i,
                         exp_rdata_i, csr_rdata_i);
            end
        end
    end

    assign error_count_o = errors;
    assign check_count_o = checks;

endmodule

// File: verif/tb_fetch_frontend.sv
module tb_fetch_frontend;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_ROWS = 32;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS + 20;

    // short names for the table
    localparam fetch_pkg::csr_addr_t EENTRY = fetch_pkg::CSR_EENTRY;
    localparam fetch_pkg::csr_addr_t ERA = fetch_pkg::CSR_ERA;
    localparam fetch_pkg::csr_addr_t CTRL = fetch_pkg::CSR_CTRL;
    localparam fetch_pkg::bp_update_t NO_UPD = '0;
    localparam fetch_pkg::bp_update_t UPD_TAKEN = {1'b1, 1'b1, 32'h2020, 32'h3000};
    localparam fetch_pkg::bp_update_t UPD_NOT_TAKEN = {1'b1, 1'b0, 32'h2020, 32'h0};
    localparam fetch_pkg::csr_wr_t NO_WR = '0;
    localparam fetch_pkg::csr_wr_t WR_EENTRY = {1'b1, fetch_pkg::CSR_EENTRY, 32'h2000};
    localparam fetch_pkg::csr_wr_t WR_IRQ_EN = {1'b1, fetch_pkg::CSR_CTRL, 32'h1};

    // ctl is {stall, redirect, flush, irq}
    typedef struct packed {
        logic [159:0]           name;
        logic [3:0]             ctl;
        fetch_pkg::fetch_addr_t redirect_pc;
        fetch_pkg::bp_update_t  upd;
        fetch_pkg::csr_wr_t     wr;
        fetch_pkg::csr_addr_t   raddr;
        fetch_pkg::fetch_pkt_t  exp_pkt;
        fetch_pkg::fetch_addr_t exp_rdata;
    } row_t;

    logic clk, rst, stall, redirect, exc_flush, irq;
    fetch_pkg::fetch_addr_t redirect_pc, csr_rdata;
    fetch_pkg::bp_update_t  bp_upd;
    fetch_pkg::csr_wr_t     csr_wr;
    fetch_pkg::csr_addr_t   csr_raddr;
    fetch_pkg::fetch_pkt_t  fetch_pkt;

    // expected values handed to the checker
    logic                   check_en;
    logic [159:0]           check_name;
    fetch_pkg::fetch_pkt_t  check_pkt;
    fetch_pkg::fetch_addr_t check_rdata;
    int                     error_count, check_count;

    row_t rows [NUM_ROWS];
    int   row_count;

    // 40 ns period
    always #20 clk = ~clk;

    // flags are {valid, pred_taken, excp_int, excp_adef}
    task automatic add_row(input logic [159:0] name, input logic [3:0] ctl,
                           input fetch_pkg::fetch_addr_t redirect_pc,
                           input fetch_pkg::bp_update_t upd, input fetch_pkg::csr_wr_t wr,
                           input fetch_pkg::csr_addr_t raddr,
                           input fetch_pkg::fetch_addr_t exp_pc, input logic [3:0] flags,
                           input fetch_pkg::fetch_addr_t exp_rdata);
        row_t r;
        r = {name, ctl, redirect_pc, upd, wr, raddr, flags[3], exp_pc, flags[2:0], exp_rdata};
        rows[row_count] = r;
        row_count++;
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    task automatic fill_table();
        fetch_pkg::fetch_addr_t target;
        int k;
        // first group is the reset vector itself, then +8 per cycle
        add_row("seq_first", 4'b0000, 'h0, NO_UPD, NO_WR, EENTRY, 'h100, 4'b1000, 0);
        for (k = 1; k <= 3; k++) begin
            add_row("seq_step", 4'b0000, 'h0, NO_UPD, NO_WR, EENTRY, 'h100 + 8 * k, 4'b1000, 0);
        end
        add_row("stall_hold", 4'b1000, 'h0, NO_UPD, NO_WR, EENTRY, 'h118, 4'b1000, 0);
        add_row("stall_hold", 4'b1000, 'h0, NO_UPD, NO_WR, EENTRY, 'h118, 4'b1000, 0);
        add_row("stall_redirect", 4'b1100, 'h400, NO_UPD, NO_WR, EENTRY, 'h400, 4'b1000, 0);
        add_row("eentry_write", 4'b0000, 'h0, NO_UPD, WR_EENTRY, EENTRY, 'h408, 4'b1000, 'h2000);
        // era takes the pc current at the flush
        add_row("flush_over_redirect", 4'b0110, 'h800, NO_UPD, NO_WR, ERA, 'h2000, 4'b1000, 'h408);
        add_row("after_flush", 4'b0000, 'h0, NO_UPD, NO_WR, ERA, 'h2008, 4'b1000, 'h408);
        // branch at 0x2020 goes to 0x3000
        add_row("btb_train", 4'b0000, 'h0, UPD_TAKEN, NO_WR, ERA, 'h2010, 4'b1000, 'h408);
        add_row("seq_to_branch", 4'b0000, 'h0, NO_UPD, NO_WR, ERA, 'h2018, 4'b1000, 'h408);
        add_row("seq_to_branch", 4'b0000, 'h0, NO_UPD, NO_WR, ERA, 'h2020, 4'b1000, 'h408);
        add_row("btb_taken", 4'b0000, 'h0, NO_UPD, NO_WR, ERA, 'h3000, 4'b1100, 'h408);
        add_row("after_taken", 4'b0000, 'h0, NO_UPD, NO_WR, ERA, 'h3008, 4'b1000, 'h408);
        add_row("redirect_untrain", 4'b0100, 'h2010, UPD_NOT_TAKEN, NO_WR, ERA, 'h2010, 4'b1000,
                'h408);
        add_row("seq_to_branch", 4'b0000, 'h0, NO_UPD, NO_WR, ERA, 'h2018, 4'b1000, 'h408);
        add_row("seq_to_branch", 4'b0000, 'h0, NO_UPD, NO_WR, ERA, 'h2020, 4'b1000, 'h408);
        add_row("btb_cleared", 4'b0000, 'h0, NO_UPD, NO_WR, ERA, 'h2028, 4'b1000, 'h408);
        add_row("misaligned_redirect", 4'b0100, 'h4002, NO_UPD, NO_WR, ERA, 'h4002, 4'b1001, 'h408);
        add_row("realign_redirect", 4'b0100, 'h5000, NO_UPD, NO_WR, ERA, 'h5000, 4'b1000, 'h408);
        // interrupt enable still off here
        add_row("irq_disabled", 4'b0001, 'h0, NO_UPD, NO_WR, CTRL, 'h5008, 4'b1000, 0);
        add_row("irq_enable_write", 4'b0000, 'h0, NO_UPD, WR_IRQ_EN, CTRL, 'h5010, 4'b1000, 1);
        add_row("irq_marked", 4'b0001, 'h0, NO_UPD, NO_WR, CTRL, 'h5018, 4'b1010, 1);
        add_row("irq_dropped", 4'b0000, 'h0, NO_UPD, NO_WR, CTRL, 'h5020, 4'b1000, 1);
        target = '0;
        for (k = 0; k < 6; k++) begin
            target = $urandom;
            add_row("random_redirect", 4'b0100, target, NO_UPD, NO_WR, CTRL, target,
                    {3'b100, target[1:0] != 2'b00}, 1);
        end
        add_row("seq_after_random", 4'b0000, 'h0, NO_UPD, NO_WR, CTRL,
                target + fetch_pkg::FETCH_STRIDE, {3'b100, target[1:0] != 2'b00}, 1);
    endtask

    task automatic apply_inputs(input row_t r);
        stall = r.ctl[3];
        redirect = r.ctl[2];
        exc_flush = r.ctl[1];
        irq = r.ctl[0];
        redirect_pc = r.redirect_pc;
        bp_upd = r.upd;
        csr_wr = r.wr;
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'hd3fee38c));
        clk = 1'b0;
        rst = 1'b1;
        apply_inputs('0);
        csr_raddr = EENTRY;
        check_en = 1'b0;
        check_name = '0;
        check_pkt = '0;
        check_rdata = '0;
        row_count = 0;
        fill_table();
        repeat (RESET_CYCLES - 1) @(posedge clk);
        #2;
        // still in reset, packet parked on the reset vector
        check_en = 1'b1;
        check_name = "reset_hold";
        check_pkt = {1'b0, fetch_pkg::RESET_PC, 3'b000};
        @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i <= NUM_ROWS; i++) begin
            if (i < NUM_ROWS) begin
                apply_inputs(rows[i]);
            end else begin
                apply_inputs('0);
            end
            check_en = (i > 0);
            if (i > 0) begin
                // read address trails by a cycle so a row reads back its own write
                csr_raddr = rows[i-1].raddr;
                check_name = rows[i-1].name;
                check_pkt = rows[i-1].exp_pkt;
                check_rdata = rows[i-1].exp_rdata;
            end
            @(posedge clk);
            #2;
        end
        check_en = 1'b0;
        $display("errors %0d, checks %0d", error_count, check_count);
        if (check_count != NUM_ROWS + 1) begin
            $display("checker ran %0d checks instead of %0d", check_count, NUM_ROWS + 1);
        end
        if (error_count == 0 && check_count == NUM_ROWS + 1) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    fetch_frontend u_fetch_frontend (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .exc_flush_i   (exc_flush),
        .irq_i         (irq),
        .bp_upd_i      (bp_upd),
        .csr_wr_i      (csr_wr),
        .csr_raddr_i   (csr_raddr),
        .fetch_pkt_o   (fetch_pkt),
        .csr_rdata_o   (csr_rdata)
    );

    fetch_checker u_fetch_checker (
        .clk           (clk),
        .check_en_i    (check_en),
        .test_name_i   (check_name),
        .exp_pkt_i     (check_pkt),
        .exp_rdata_i   (check_rdata),
        .fetch_pkt_i   (fetch_pkt),
        .csr_rdata_i   (csr_rdata),
        .error_count_o (error_count),
        .check_count_o (check_count)
    );

endmodule

// File: fetch_frontend.f
hdl/fetch_pkg.sv
hdl/fetch_csr.sv
hdl/branch_target_buffer.sv
hdl/pc_gen.sv
hdl/fetch_frontend.sv
verif/fetch_checker.sv
verif/tb_fetch_frontend.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps
TOP      := tb_fetch_frontend
FILELIST := fetch_frontend.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# passes only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
